/* project.f */
hdl/nes_io_pkg.sv
hdl/nes_reset_sequencer.sv
hdl/joypad_channel.sv
hdl/rv_sdram_bridge.sv
hdl/nes_io_top.sv
dv/sdram_port_model.sv
dv/tb_nes_io.sv

/* dv/tb_nes_io.sv */
/*
 * Testbench for the NES I/O glue: joypad readout, autofire,
 * reset sequencing and the SDRAM bridge against a behavioral memory.
 * Inputs change on the falling clock edge, outputs are sampled there too.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_nes_io;

    localparam int MAX_CYCLES = 120000;

    logic                      clk;
    logic                      sys_resetn;
    nes_io_pkg::snes_buttons_t pad_buttons [nes_io_pkg::NUM_PADS];
    logic                      joypad_strobe;
    logic                      joypad_clock [nes_io_pkg::NUM_PADS];
    logic                      joypad_data [nes_io_pkg::NUM_PADS];
    logic                      loading, nes_reset, loader_reset;
    logic                      rv_valid, rv_ready;
    nes_io_pkg::rv_addr_t      rv_addr;
    nes_io_pkg::rv_data_t      rv_wdata, rv_rdata;
    nes_io_pkg::rv_strb_t      rv_wstrb;
    logic                      mem_req, mem_ack, mem_we;
    nes_io_pkg::mem_addr_t     mem_addr;
    nes_io_pkg::mem_data_t     mem_din, mem_dout;
    nes_io_pkg::mem_ds_t       mem_ds;
    int                        toggles;
    int                        cycles;
    logic [31:0]               seed;
    logic [15:0]               shadow [1024];

    nes_io_top uut (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_pad_buttons(pad_buttons), .i_joypad_strobe(joypad_strobe),
        .i_joypad_clock(joypad_clock), .o_joypad_data(joypad_data),
        .i_loading(loading), .o_nes_reset(nes_reset), .o_loader_reset(loader_reset),
        .i_rv_valid(rv_valid), .i_rv_addr(rv_addr), .i_rv_wdata(rv_wdata),
        .i_rv_wstrb(rv_wstrb), .o_rv_ready(rv_ready), .o_rv_rdata(rv_rdata),
        .o_mem_req(mem_req), .i_mem_ack(mem_ack), .o_mem_addr(mem_addr),
        .o_mem_din(mem_din), .o_mem_ds(mem_ds), .o_mem_we(mem_we),
        .i_mem_dout(mem_dout)
    );

    sdram_port_model u_mem (
        .clk(clk), .sys_resetn(sys_resetn), .i_req(mem_req), .o_ack(mem_ack),
        .i_addr(mem_addr), .i_din(mem_din), .i_ds(mem_ds), .i_we(mem_we),
        .o_dout(mem_dout), .o_toggles(toggles)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act)
        else stop_run($sformatf("MISMATCH at %0t: %s expected %0h got %0h",
                                $time, name, exp, act));
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            stop_run($sformatf("timeout after %0d cycles, bridge in %s",
                               cycles, uut.u_bridge.state.name()));
    end

    ////////////////////////////////////////
    // concurrent checks
    ////////////////////////////////////////

    a_ready_after_ack: assert property (
        @(posedge clk) disable iff (!sys_resetn) rv_ready |-> (mem_req == mem_ack)
    ) else stop_run("bus ready while an SDRAM access was outstanding");

    a_loader_on_rise: assert property (
        @(posedge clk) disable iff (!sys_resetn)
        loader_reset |-> ($past(loading) && !$past(loading, 2))
    ) else stop_run("loader reset without a loading rise one cycle before");

    ////////////////////////////////////////
    // joypad tests
    ////////////////////////////////////////

    task automatic serial_readout();
        nes_io_pkg::snes_buttons_t b [2];
        for (int p = 0; p < 2; p++) begin
            seed = lcg_next(seed);
            b[p] = seed[27:16] & 12'hcff;              // turbo released
            pad_buttons[p] = b[p];
        end
        joypad_strobe = 1'b1;
        @(negedge clk);
        joypad_strobe = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            for (int p = 0; p < 2; p++)
                check_value($sformatf("o_joypad_data[%0d] bit %0d", p, i),
                            (i < 8) ? b[p][i] : 1'b1, joypad_data[p]);
            joypad_clock[0] = 1'b1;
            joypad_clock[1] = 1'b1;
            @(negedge clk);
            joypad_clock[0] = 1'b0;
            joypad_clock[1] = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic autofire_test();
        logic exp_bit;
        logic pending;
        pad_buttons[0] = 12'h100;                      // turbo A, B button up
        pad_buttons[1] = 12'h001;
        pending = 1'b0;
        // n is the counter value in the cycle its strobe is sampled
        for (int n = 0; n < 3 * 8192 + 16; n++) begin
            if (pending) begin
                check_value("o_joypad_data[0] autofire", exp_bit, joypad_data[0]);
                check_value("o_joypad_data[1] plain B", 1'b1, joypad_data[1]);
            end
            pending = (n % 613 == 0) || ((n + 1) % 8192 < 3);
            joypad_strobe = pending;
            exp_bit = n[13];
            @(negedge clk);
        end
        // autofire bit is high here, release must clear it
        pad_buttons[0] = 12'h000;
        joypad_strobe = 1'b0;
        @(negedge clk);
        joypad_strobe = 1'b1;
        @(negedge clk);
        joypad_strobe = 1'b0;
        @(negedge clk);
        check_value("o_joypad_data[0] turbo released", 1'b0, joypad_data[0]);
    endtask

    ////////////////////////////////////////
    // reset sequencing
    ////////////////////////////////////////

    task automatic reset_tests();
        check_value("o_nes_reset after reset", 1'b1, nes_reset);
        loading = 1'b1;
        @(negedge clk);
        check_value("o_loader_reset", 1'b1, loader_reset);
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_value("o_loader_reset", 1'b0, loader_reset);
            check_value("o_nes_reset", 1'b1, nes_reset);
        end
        loading = 1'b0;
        @(negedge clk);
        check_value("o_nes_reset after load", 1'b0, nes_reset);
        pad_buttons[0] = 12'h00c;                      // select + start
        @(negedge clk);
        check_value("o_nes_reset combo held", 1'b1, nes_reset);
        pad_buttons[0] = 12'h004;
        @(negedge clk);
        check_value("o_nes_reset combo released", 1'b0, nes_reset);
        pad_buttons[0] = 12'h000;
        pad_buttons[1] = 12'h00c;
        repeat (4) begin
            @(negedge clk);
            check_value("o_nes_reset pad 1 combo", 1'b0, nes_reset);
        end
        pad_buttons[1] = 12'h000;
    endtask

    ////////////////////////////////////////
    // bridge traffic
    ////////////////////////////////////////

    task automatic bus_access(input nes_io_pkg::rv_addr_t a, input nes_io_pkg::rv_data_t wd,
                              input nes_io_pkg::rv_strb_t st);
        int lo;
        int t0;
        int exp_tog;
        logic [31:0] exp_rd;
        lo = {a[10:2], 1'b0};
        t0 = toggles;
        exp_rd = {shadow[lo+1], shadow[lo]};
        exp_tog = (st == 0) ? 2 : int'(|st[1:0]) + int'(|st[3:2]);
        rv_valid = 1'b1;
        rv_addr = a;
        rv_wdata = wd;
        rv_wstrb = st;
        @(negedge clk);
        while (!rv_ready)
            @(negedge clk);
        check_value("SDRAM toggles", exp_tog, toggles - t0);
        if (st == 0)
            check_value("o_rv_rdata", exp_rd, rv_rdata);
        for (int b = 0; b < 4; b++)
            if (st[b])
                shadow[lo + b / 2][8 * (b % 2) +: 8] = wd[8 * b +: 8];
        rv_valid = 1'b0;
        seed = lcg_next(seed);
        repeat (1 + seed[17:16]) begin
            @(negedge clk);
            check_value("o_rv_ready extra pulse", 1'b0, rv_ready);
        end
    endtask

    task automatic bus_traffic();
        nes_io_pkg::rv_strb_t st;
        for (int i = 0; i < 1024; i++)
            shadow[i] = 16'(i * 16'h3a7) ^ {i[9:0], 6'h15};
        for (int i = 0; i < 200; i++) begin
            seed = lcg_next(seed);
            case (seed[19:17])
                3'd0, 3'd1: st = 4'b0000;
                3'd2:       st = 4'b0011;
                3'd3:       st = 4'b1100;
                default:    st = seed[23:20];
            endcase
            // small address window so rereads hit earlier writes
            bus_access({12'd0, 3'd0, seed[29:24], 2'b00}, lcg_next(seed), st);
        end
    endtask

    initial begin
        cycles = 0;
        seed = 32'hb90b850f;
        sys_resetn = 1'b0;
        pad_buttons[0] = '0;
        pad_buttons[1] = '0;
        joypad_strobe = 1'b0;
        joypad_clock[0] = 1'b0;
        joypad_clock[1] = 1'b0;
        loading = 1'b0;
        rv_valid = 1'b0;
        rv_addr = '0;
        rv_wdata = '0;
        rv_wstrb = '0;
        repeat (3) @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);
        reset_tests();
        repeat (4) serial_readout();
        autofire_test();
        bus_traffic();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/sdram_port_model.sv */
/*
 * Behavioral 16-bit SDRAM port with toggle req/ack, 1024 words.
 * Acks 0 to 5 cycles after it sees a toggle, delay from an LCG.
 * Only word address bits 9..0 are used. Counts every toggle it serves.
 */

`timescale 1ns/1ps
`default_nettype none

module sdram_port_model (
    input  wire                    clk,
    input  wire                    sys_resetn,
    input  wire                    i_req,
    output logic                   o_ack,
    input  nes_io_pkg::mem_addr_t  i_addr,
    input  nes_io_pkg::mem_data_t  i_din,
    input  nes_io_pkg::mem_ds_t    i_ds,
    input  wire                    i_we,
    output nes_io_pkg::mem_data_t  o_dout,
    output int                     o_toggles
);

    logic [15:0] mem [1024];
    logic [31:0] seed;
    logic        busy;
    int          delay;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // same fill rule as the testbench shadow
    initial begin
        for (int i = 0; i < 1024; i++)
            mem[i] = 16'(i * 16'h3a7) ^ {i[9:0], 6'h15};
    end

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            o_ack     <= 1'b0;
            o_dout    <= '0;
            o_toggles <= 0;
            busy      <= 1'b0;
            delay     <= 0;
            seed      <= 32'hb90b850f;
        end else if (!busy && (i_req != o_ack)) begin
            busy      <= 1'b1;                     // new access seen
            o_toggles <= o_toggles + 1;
            seed      <= lcg_next(seed);
            delay     <= int'((seed >> 16) % 6);
        end else if (busy) begin
            if (delay == 0) begin
                if (i_we) begin
                    if (i_ds[0])
                        mem[i_addr[9:0]][7:0] <= i_din[7:0];
                    if (i_ds[1])
                        mem[i_addr[9:0]][15:8] <= i_din[15:8];
                end else begin
                    o_dout <= mem[i_addr[9:0]];
                end
                o_ack <= i_req;
                busy  <= 1'b0;
            end else begin
                delay <= delay - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/nes_io_top.sv */
/*
 * Input and housekeeping glue around the NES core: joypad ports,
 * console reset sequencing and the softcore to SDRAM bridge.
 * Everything runs on clk; inputs are assumed already synchronous.
 */

`timescale 1ns/1ps
`default_nettype none

module nes_io_top (
    input  wire                        clk,
    input  wire                        sys_resetn,
    // joypads
    input  nes_io_pkg::snes_buttons_t  i_pad_buttons [nes_io_pkg::NUM_PADS],
    input  wire                        i_joypad_strobe,
    input  wire                        i_joypad_clock [nes_io_pkg::NUM_PADS],
    output logic                       o_joypad_data [nes_io_pkg::NUM_PADS],
    // reset
    input  wire                        i_loading,
    output logic                       o_nes_reset,
    output logic                       o_loader_reset,
    // softcore bus
    input  wire                        i_rv_valid,
    input  nes_io_pkg::rv_addr_t       i_rv_addr,
    input  nes_io_pkg::rv_data_t       i_rv_wdata,
    input  nes_io_pkg::rv_strb_t       i_rv_wstrb,
    output logic                       o_rv_ready,
    output nes_io_pkg::rv_data_t       o_rv_rdata,
    // SDRAM port
    output logic                       o_mem_req,
    input  wire                        i_mem_ack,
    output nes_io_pkg::mem_addr_t      o_mem_addr,
    output nes_io_pkg::mem_data_t      o_mem_din,
    output nes_io_pkg::mem_ds_t        o_mem_ds,
    output logic                       o_mem_we,
    input  nes_io_pkg::mem_data_t      i_mem_dout
);

    // combo only watches the first pad
    nes_reset_sequencer u_reset_seq (
        .clk            (clk),
        .sys_resetn     (sys_resetn),
        .i_loading      (i_loading),
        .i_p1_buttons   (i_pad_buttons[0]),
        .o_nes_reset    (o_nes_reset),
        .o_loader_reset (o_loader_reset)
    );

    for (genvar p = 0; p < nes_io_pkg::NUM_PADS; p++) begin : g_pad
        joypad_channel u_pad (
            .clk         (clk),
            .sys_resetn  (sys_resetn),
            .i_buttons   (i_pad_buttons[p]),
            .i_strobe    (i_joypad_strobe),     // shared by both ports
            .i_pad_clock (i_joypad_clock[p]),
            .o_data      (o_joypad_data[p])
        );
    end

    rv_sdram_bridge u_bridge (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_rv_valid (i_rv_valid),
        .i_rv_addr  (i_rv_addr),
        .i_rv_wdata (i_rv_wdata),
        .i_rv_wstrb (i_rv_wstrb),
        .o_rv_ready (o_rv_ready),
        .o_rv_rdata (o_rv_rdata),
        .o_mem_req  (o_mem_req),
        .i_mem_ack  (i_mem_ack),
        .o_mem_addr (o_mem_addr),
        .o_mem_din  (o_mem_din),
        .o_mem_ds   (o_mem_ds),
        .o_mem_we   (o_mem_we),
        .i_mem_dout (i_mem_dout)
    );

endmodule

`default_nettype wire

/* hdl/rv_sdram_bridge.sv */
/*
 * Splits a 32-bit softcore access into one or two 16-bit toggle requests.
 * The master holds valid, address, data and strobes until the ready pulse.
 * Only byte address bits 20..2 reach the SDRAM port.
 * Read data is valid in the ready cycle only, until the next request toggles.
 */

`timescale 1ns/1ps
`default_nettype none

module rv_sdram_bridge (
    input  wire                    clk,
    input  wire                    sys_resetn,
    // softcore side
    input  wire                    i_rv_valid,
    input  nes_io_pkg::rv_addr_t   i_rv_addr,
    input  nes_io_pkg::rv_data_t   i_rv_wdata,
    input  nes_io_pkg::rv_strb_t   i_rv_wstrb,
    output logic                   o_rv_ready,
    output nes_io_pkg::rv_data_t   o_rv_rdata,
    // SDRAM port
    output logic                   o_mem_req,
    input  wire                    i_mem_ack,
    output nes_io_pkg::mem_addr_t  o_mem_addr,
    output nes_io_pkg::mem_data_t  o_mem_din,
    output nes_io_pkg::mem_ds_t    o_mem_ds,
    output logic                   o_mem_we,
    input  nes_io_pkg::mem_data_t  i_mem_dout
);

    nes_io_pkg::bridge_state_t state;
    nes_io_pkg::mem_data_t     rdata_lo;

    logic rv_valid_r;
    logic req_pending;      // valid rise seen while busy
    logic new_req;
    logic start;
    logic word_sel;         // 0 low word, 1 high word
    logic is_write;
    logic write_lo;
    logic write_hi;
    logic mem_done;

    assign new_req  = i_rv_valid & ~rv_valid_r;
    assign start    = new_req | req_pending;
    assign is_write = |i_rv_wstrb;
    assign write_lo = |i_rv_wstrb[1:0];
    assign write_hi = |i_rv_wstrb[3:2];
    assign mem_done = (o_mem_req == i_mem_ack);

    // address, data and direction come straight from the held bus request
    assign o_mem_addr = {i_rv_addr[20:2], word_sel};
    assign o_mem_din  = word_sel ? i_rv_wdata[31:16] : i_rv_wdata[15:0];
    assign o_mem_we   = is_write;
    assign o_rv_rdata = {i_mem_dout, rdata_lo};

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state       <= nes_io_pkg::IDLE;
            rv_valid_r  <= 1'b0;
            req_pending <= 1'b0;
            o_rv_ready  <= 1'b0;
            o_mem_req   <= 1'b0;
            word_sel    <= 1'b0;
            o_mem_ds    <= '0;
        end else begin
            rv_valid_r <= i_rv_valid;
            o_rv_ready <= 1'b0;
            if (new_req)
                req_pending <= 1'b1;

            case (state)
                nes_io_pkg::IDLE: begin
                    if (start) begin
                        req_pending <= 1'b0;
                        o_mem_req   <= ~o_mem_req;
                        if (is_write && !write_lo) begin
                            // high half only
                            word_sel <= 1'b1;
                            o_mem_ds <= i_rv_wstrb[3:2];
                            state    <= nes_io_pkg::WAIT_HI;
                        end else begin
                            word_sel <= 1'b0;
                            o_mem_ds <= is_write ? i_rv_wstrb[1:0] : 2'b11;
                            state    <= nes_io_pkg::WAIT_LO;
                        end
                    end
                end

                nes_io_pkg::WAIT_LO: begin
                    if (mem_done) begin
                        if (!is_write) begin
                            state <= nes_io_pkg::DATA_LO;
                        end else if (!write_hi) begin
                            o_rv_ready <= 1'b1;        // low half only
                            state      <= nes_io_pkg::IDLE;
                        end else begin
                            o_mem_req <= ~o_mem_req;
                            word_sel  <= 1'b1;
                            o_mem_ds  <= i_rv_wstrb[3:2];
                            state     <= nes_io_pkg::WAIT_HI;
                        end
                    end
                end

                nes_io_pkg::DATA_LO: begin
                    rdata_lo  <= i_mem_dout;    // still valid, no toggle yet
                    o_mem_req <= ~o_mem_req;
                    word_sel  <= 1'b1;
                    o_mem_ds  <= 2'b11;
                    state     <= nes_io_pkg::WAIT_HI;
                end

                nes_io_pkg::WAIT_HI: begin
                    if (mem_done) begin
                        if (is_write) begin
                            o_rv_ready <= 1'b1;
                            state      <= nes_io_pkg::IDLE;
                        end else begin
                            state <= nes_io_pkg::DATA_HI;
                        end
                    end
                end

                nes_io_pkg::DATA_HI: begin
                    o_rv_ready <= 1'b1;         // high word held on i_mem_dout
                    state      <= nes_io_pkg::IDLE;
                end

                default: state <= nes_io_pkg::IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // no new toggle while the SDRAM side still owes an ack
    a_req_after_ack: assert property (
        @(posedge clk) disable iff (!sys_resetn)
        (o_mem_req != i_mem_ack) |=> $stable(o_mem_req)
    ) else $error("SDRAM request toggled before previous ack");

    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!sys_resetn)
        o_rv_ready |=> !o_rv_ready
    ) else $error("bus ready high for two cycles");

endmodule

`default_nettype wire

/* hdl/joypad_channel.sv */
/*
 * One NES controller port. Strobe and port clock are levels from the console,
 * sampled on clk; the port clock must stay in each phase for at least a cycle.
 * Strobe wins over a shift in the same cycle. After 8 shifts the port reads 1.
 */

`timescale 1ns/1ps
`default_nettype none

module joypad_channel (
    input  wire                        clk,
    input  wire                        sys_resetn,
    input  nes_io_pkg::snes_buttons_t  i_buttons,
    input  wire                        i_strobe,
    input  wire                        i_pad_clock,
    output logic                       o_data
);

    localparam int AF_MSB = nes_io_pkg::AUTOFIRE_BITS - 1;

    logic [AF_MSB:0]      af_cnt [2];    // 0 for turbo A, 1 for turbo B
    logic [1:0]           turbo_btn;
    logic [1:0]           af_bit;
    logic                 pad_clock_r;
    logic                 pad_fall;
    nes_io_pkg::nes_pad_t pad_bits;
    nes_io_pkg::nes_pad_t pad_load;

    ////////////////////////////////////////
    // autofire
    ////////////////////////////////////////

    assign turbo_btn = {i_buttons[nes_io_pkg::BTN_TURBO_B],
                        i_buttons[nes_io_pkg::BTN_TURBO_A]};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (!sys_resetn || !turbo_btn[i])
                af_cnt[i] <= '0;               // restart on every press
            else
                af_cnt[i] <= af_cnt[i] + 1'b1; // wraps, so it keeps toggling
        end
    end

    // low for the first half period after the press
    assign af_bit = {af_cnt[1][AF_MSB], af_cnt[0][AF_MSB]};

    ////////////////////////////////////////
    // shift register
    ////////////////////////////////////////

    // turbo merged into NES A (bit 0) and NES B (bit 1)
    assign pad_load = {i_buttons[7:2],
                       i_buttons[1] | af_bit[1],
                       i_buttons[0] | af_bit[0]};

    assign pad_fall = pad_clock_r & ~i_pad_clock;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            pad_clock_r <= 1'b0;
            pad_bits    <= '1;               // reads as nothing pressed
        end else begin
            pad_clock_r <= i_pad_clock;
            if (i_strobe)
                pad_bits <= pad_load;        // reload every cycle while high
            else if (pad_fall)
                pad_bits <= {1'b1, pad_bits[7:1]};
        end
    end

    assign o_data = pad_bits[0];

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a plain shift always brings a 1 in at the top
    a_shift_fill: assert property (
        @(posedge clk) disable iff (!sys_resetn)
        (pad_fall && !i_strobe) |=> pad_bits[7]
    ) else $error("joypad shift did not fill with 1");

endmodule

`default_nettype wire

/* hdl/nes_reset_sequencer.sv */
/*
 * Console reset follows the loading level and the Select+Start combo on pad 0.
 * Buttons and loading are assumed synchronous to clk.
 * All outputs are registered and move one cycle after the sampled event.
 */

`timescale 1ns/1ps
`default_nettype none

module nes_reset_sequencer (
    input  wire                        clk,
    input  wire                        sys_resetn,
    input  wire                        i_loading,
    input  nes_io_pkg::snes_buttons_t  i_p1_buttons,
    output logic                       o_nes_reset,
    output logic                       o_loader_reset
);

    logic loading_r;
    logic combo_r;
    logic combo;

    assign combo = i_p1_buttons[nes_io_pkg::BTN_SELECT] &
                   i_p1_buttons[nes_io_pkg::BTN_START];

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r      <= 1'b0;
            combo_r        <= 1'b0;
            o_nes_reset    <= 1'b1;    // console held until a rom is loaded
            o_loader_reset <= 1'b0;
        end else begin
            loading_r      <= i_loading;
            combo_r        <= combo;
            o_loader_reset <= i_loading & ~loading_r;

            // combo press and release
            if (combo && !combo_r)
                o_nes_reset <= 1'b1;
            else if (!combo && combo_r && !i_loading)
                o_nes_reset <= 1'b0;

            // loading edges take priority over the combo
            if (i_loading && !loading_r)
                o_nes_reset <= 1'b1;
            else if (!i_loading && loading_r)
                o_nes_reset <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // loader reset is a single pulse per load
    a_loader_pulse: assert property (
        @(posedge clk) disable iff (!sys_resetn)
        o_loader_reset |=> !o_loader_reset
    ) else $error("loader reset held for more than one cycle");

endmodule

`default_nettype wire

/* hdl/nes_io_pkg.sv */
/*
 * Shared widths, button positions and bridge states for the NES I/O glue.
 * Button words use the SNES layout; the low 8 bits are the NES buttons.
 * The softcore address only uses bits 20..2 at the SDRAM port (2 MB window).
 */

`default_nettype none

package nes_io_pkg;

    ////////////////////////////////////////
    // joypads
    ////////////////////////////////////////

    localparam int NUM_PADS      = 2;
    localparam int AUTOFIRE_BITS = 14;   // turbo period is 2^14 cycles

    // bit 0 upward: B Y SELECT START UP DOWN LEFT RIGHT A X L R
    typedef logic [11:0] snes_buttons_t;
    typedef logic [7:0]  nes_pad_t;      // NES shift register, A in bit 0

    localparam int BTN_SELECT  = 2;
    localparam int BTN_START   = 3;
    localparam int BTN_TURBO_A = 8;      // SNES A drives autofire on NES A
    localparam int BTN_TURBO_B = 9;      // SNES X drives autofire on NES B

    ////////////////////////////////////////
    // softcore bus and SDRAM port
    ////////////////////////////////////////

    localparam int RV_ADDR_W  = 23;
    localparam int RV_DATA_W  = 32;
    localparam int MEM_ADDR_W = 20;
    localparam int MEM_DATA_W = 16;

    typedef logic [RV_ADDR_W-1:0]    rv_addr_t;   // byte address
    typedef logic [RV_DATA_W-1:0]    rv_data_t;
    typedef logic [RV_DATA_W/8-1:0]  rv_strb_t;   // nonzero means write
    typedef logic [MEM_ADDR_W-1:0]   mem_addr_t;  // 16-bit word address
    typedef logic [MEM_DATA_W-1:0]   mem_data_t;
    typedef logic [MEM_DATA_W/8-1:0] mem_ds_t;    // byte selects

    typedef enum logic [2:0] {
        IDLE,       // waiting for a valid rise, issues the first request
        WAIT_LO,    // low word outstanding
        DATA_LO,    // low read word captured, high request issued
        WAIT_HI,    // high word outstanding
        DATA_HI     // read done, ready follows
    } bridge_state_t;

endpackage

`default_nettype wire
